/* mdc_golden.txt */
// per vector: mode codeword, sixteen data codewords in row-major order,
// then the expected 207-bit out_data (all zero when the mode is invalid)
0A8 6881 2882 4003 4884 2005 7FFF 0000 2882 177E 4003 6881 7FFF 0000 4884 577D 2882
7FFFF500000600001800006FFFFFFFFFFFDFFFFE3FFFF9FFFFFF
10C 2882 0000 7FFF 4003 6881 4884 2882 0000 577D 6881 2005 177E 0000 2882 7FFF 6881
000000000002E00000000000BBFFFFFFFFFFEE8000000000002
1A8 6880 2882 4003 4884 2005 7FEF 0000 2882 577E 4003 6881 7FFF 0000 4884 577C 2882
7FFFF500000600001800006FFFFFFFFFFFDFFFFE3FFFF9FFFFFF
000 6881 2882 4003 4884 2005 7FFF 0000 2882 177E 4003 6881 7FFF 0000 4884 577D 2882
0000000000000000000000000000000000000000000000000000
10D 2882 0000 7FFF 4803 6881 4884 2882 0000 557D 6881 2005 177F 0000 2882 7FFF 6081
000000000002E00000000000BBFFFFFFFFFFEE8000000000002
10C 6881 2882 4003 4884 2005 7FFF 0000 2882 177E 4003 6881 7FFF 0000 4884 577D 2882
0000000000003800000000000 1FFFFFFFFFFFE2FFFFFFFFFFFE7
0A8 2882 0000 7FFF 4003 6881 4884 2882 0000 577D 6881 2005 177E 0000 2882 7FFF 6881
000008000009FFFFE800006800012FFFFF9FFFFEBFFFFA800003

/* tb.f */
+incdir+.
mdc_pkg.sv
hamming_decoder.sv
mdc_input_stage.sv
matrix_buffer.sv
det_engine.sv
mdc_top.sv
mdc_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary -f tb.f --top-module mdc_tb -o mdc_sim
out=$(./obj_dir/mdc_sim 2>&1 || true)
echo "$out"
if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* mdc_tb_checks.svh */
// compare tasks for out_data and the out_valid pulse width,
// plus the helper that ends a failing run
`ifndef MDC_TB_CHECKS_SVH
`define MDC_TB_CHECKS_SVH

// ========================================
// failure path
// ========================================

// prints the reason, then the fail line, then stops the run
task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
endtask

// ========================================
// compare tasks
// ========================================

// full 207-bit result word against the expected value
task automatic check_result(input string name,
                            input mdc_pkg::result_t got,
                            input mdc_pkg::result_t exp);
    string line;
    if (got !== exp) begin
        line = $sformatf("error: %s got 0x%h expected 0x%h", name, got, exp);
        report_failure(line);
    end
endtask

// out_valid may never stay high on two sampled cycles in a row
task automatic check_valid_width(input logic cur,
                                 input logic prev);
    string line;
    if (cur === 1'bx || cur === 1'bz) begin
        line = $sformatf("error: out_valid got 0x%h, expected 0x0 or 0x1", cur);
        report_failure(line);
    end
    if (cur && prev) begin
        line = $sformatf("error: out_valid got 0x%h after 0x%h, expected 0x0",
                         cur, prev);
        report_failure(line);
    end
endtask

`endif

/* mdc_tb.sv */
// testbench for the determinant calculator with clock, reset, golden-file
// stimulus with random gaps, output monitor and watchdog
`default_nettype none

module mdc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // one mode word, sixteen data words, one expected word per vector
    localparam int N_VEC = 7;
    localparam int WORDS = 18;
    localparam int RST_CYCLES = 16;
    localparam int WATCHDOG_CYCLES = N_VEC * 60 + RST_CYCLES;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic [8:0]       in_mode;
    logic [14:0]      in_data;
    logic             out_valid;
    mdc_pkg::result_t out_data;

    logic [207:0]     golden [0:N_VEC*WORDS-1];
    // hex numbers of the golden line being parsed
    logic [207:0]     fields [$];
    // results still owed by the DUT in arrival order
    mdc_pkg::result_t exp_q[$];
    mdc_pkg::result_t exp_word;
    int               n_expected;
    int               n_seen;
    logic             prev_valid;

    mdc_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_mode   (in_mode),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    `include "mdc_tb_checks.svh"

    // ========================================
    // golden file reading
    // ========================================

    // splits one text line into hex numbers
    // with whole set the line is one number even where spaces break its digits
    function automatic void split_hex(input string line, input bit whole);
        logic [207:0] acc;
        bit           open;
        byte          ch;
        logic [3:0]   nib;
        bit           is_hex;
        fields.delete();
        acc  = '0;
        open = 1'b0;
        for (int i = 0; i < line.len(); i++) begin
            ch     = line[i];
            is_hex = 1'b1;
            if (ch >= "0" && ch <= "9") begin
                nib = 4'(ch - "0");
            end else if (ch >= "a" && ch <= "f") begin
                nib = 4'(ch - "a" + 10);
            end else if (ch >= "A" && ch <= "F") begin
                nib = 4'(ch - "A" + 10);
            end else begin
                nib    = 4'h0;
                is_hex = 1'b0;
            end
            if (is_hex) begin
                acc  = {acc[203:0], nib};
                open = 1'b1;
            end else if (open && !whole) begin
                fields.push_back(acc);
                acc  = '0;
                open = 1'b0;
            end
        end
        if (open) begin
            fields.push_back(acc);
        end
    endfunction

    // one codeword line and one expected line per vector
    task automatic load_golden();
        int    fd;
        int    n_lines;
        int    n_want;
        int    first_idx;
        string line;
        fd = $fopen("mdc_golden.txt", "r");
        if (fd == 0) begin
            report_failure("golden file mdc_golden.txt could not be opened");
        end
        n_lines = 0;
        while (n_lines < 2 * N_VEC && $fgets(line, fd) != 0) begin
            if (line.substr(0, 1) != "//") begin
                // every second line carries the expected word
                split_hex(line, n_lines % 2 == 1);
                n_want = (n_lines % 2 == 1) ? 1 : WORDS - 1;
                if (fields.size() != 0) begin
                    if (fields.size() != n_want) begin
                        report_failure("golden file has a line with a wrong value count");
                    end
                    first_idx = (n_lines / 2) * WORDS + (n_lines % 2) * (WORDS - 1);
                    for (int j = 0; j < n_want; j++) begin
                        golden[first_idx+j] = fields[j];
                    end
                    n_lines++;
                end
            end
        end
        $fclose(fd);
        if (n_lines != 2 * N_VEC) begin
            report_failure("golden file mdc_golden.txt is missing or too short");
        end
    endtask

    // 4 ns period
    always #2 clk = ~clk;

    // ========================================
    // stimulus
    // ========================================

    initial begin
        int gap;
        int base;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_mode    = '0;
        in_data    = '0;
        n_expected = 0;
        void'($urandom(32'h036bb00d));
        load_golden();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int v = 0; v < N_VEC; v++) begin
            base = v * WORDS;
            // idle gap of 1 to 5 cycles keeps runs separated
            gap = 1 + int'($urandom % 5);
            repeat (gap) @(negedge clk);
            // zero expected word marks a bad-mode run with no output
            if (golden[base+WORDS-1][206:0] != '0) begin
                exp_q.push_back(golden[base+WORDS-1][206:0]);
                n_expected++;
            end
            for (int i = 0; i < mdc_pkg::N_ENTRIES; i++) begin
                in_valid = 1'b1;
                in_mode  = (i == 0) ? golden[base][8:0] : 9'h000;
                in_data  = golden[base+1+i][14:0];
                @(negedge clk);
            end
            in_valid = 1'b0;
            in_mode  = '0;
            in_data  = '0;
        end
        wait (n_seen == n_expected);
        // extra cycles catch a late or stray pulse
        repeat (20) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    // ========================================
    // output monitor
    // ========================================

    initial begin
        n_seen     = 0;
        prev_valid = 1'b0;
    end

    // outputs change on the rising edge and are stable at the falling one
    always @(negedge clk) begin
        check_valid_width(out_valid, prev_valid);
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("out_valid pulsed while no valid run was pending");
            end else begin
                exp_word = exp_q.pop_front();
                check_result("out_data", out_data, exp_word);
                n_seen++;
            end
        end else begin
            check_result("out_data", out_data, '0);
        end
        prev_valid = out_valid;
    end

    // ========================================
    // watchdog
    // ========================================

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("timeout: not all results arrived before the watchdog expired");
    end

endmodule

`default_nettype wire

/* mdc_top.sv */
// top level: input stage, matrix buffer and determinant engine
`default_nettype none

module mdc_top #(
    // entries per run, shared by the input stage and the buffer
    parameter int RUN_LEN = mdc_pkg::N_ENTRIES
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         in_valid,
    input  wire logic [8:0]   in_mode,
    input  wire logic [14:0]  in_data,
    output logic              out_valid,
    output mdc_pkg::result_t  out_data
);

    // ========================================
    // stage to stage links
    // ========================================

    logic                 beat_valid;
    mdc_pkg::entry_beat_t beat;
    logic                 job_valid;
    mdc_pkg::job_t        job;

    // corrects codewords, drops bad-mode runs
    mdc_input_stage #(
        .RUN_LEN (RUN_LEN)
    ) u_input_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_mode    (in_mode),
        .in_data    (in_data),
        .beat_valid (beat_valid),
        .beat       (beat)
    );

    // assembles the matrix, one job per run
    matrix_buffer #(
        .RUN_LEN (RUN_LEN)
    ) u_matrix_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .job_valid  (job_valid),
        .job        (job)
    );

    // 9 or 12 compute steps, then a one-cycle result
    det_engine u_det_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_valid (job_valid),
        .job       (job),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

/* det_engine.sv */
// determinant engine: window sequencer, shared 2x2 minor,
// 3x3 cofactor accumulation and the packed result register
`default_nettype none

module det_engine (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           job_valid,
    input  wire mdc_pkg::job_t  job,
    output logic                out_valid,
    output mdc_pkg::result_t    out_data
);

    // 11-bit pivot times 23-bit minor, summed three times
    localparam int ACC_W = 36;
    localparam int OUT_W = mdc_pkg::OUT_W;
    localparam int DET2_W = mdc_pkg::DET2_W;
    localparam int DET3_W = mdc_pkg::DET3_W;

    mdc_pkg::matrix_t          mat_q;
    mdc_pkg::det_mode_e        mode_q;
    mdc_pkg::result_t          res;
    logic                      busy;
    // window row, window column, cofactor index
    logic [1:0]                wr;
    logic [1:0]                wc;
    logic [1:0]                k;
    logic                      is_det3;
    logic [1:0]                win_max;
    logic                      win_end;
    logic                      last_step;
    logic [1:0]                row_a;
    logic [1:0]                col_a;
    logic [1:0]                col_b;
    logic signed [DET2_W-1:0]  minor;
    logic signed [ACC_W-1:0]   term;
    logic signed [ACC_W-1:0]   acc;
    logic signed [ACC_W-1:0]   acc_next;

    function automatic mdc_pkg::entry_t elem(input mdc_pkg::matrix_t m,
                                             input logic [1:0] r,
                                             input logic [1:0] c);
        return m[int'(r) * mdc_pkg::DIM + int'(c)];
    endfunction

    // ========================================
    // window sequencer
    // ========================================

    assign is_det3 = (mode_q == mdc_pkg::MODE_DET3);
    // last window origin, 2 for 2x2 windows and 1 for 3x3 windows
    assign win_max = is_det3 ? 2'(mdc_pkg::DIM - 3) : 2'(mdc_pkg::DIM - 2);
    // det2 finishes a window every step, det3 after the third cofactor
    assign win_end = !is_det3 || (k == 2'd2);
    assign last_step = busy && win_end && (wr == win_max) && (wc == win_max);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            wr        <= '0;
            wc        <= '0;
            k         <= '0;
        end else begin
            out_valid <= last_step;
            if (job_valid) begin
                busy <= 1'b1;
                wr   <= '0;
                wc   <= '0;
                k    <= '0;
            end else if (busy) begin
                if (last_step) begin
                    busy <= 1'b0;
                end
                if (!win_end) begin
                    k <= k + 2'd1;
                end else begin
                    k <= '0;
                    // row-major walk over window origins
                    if (wc == win_max) begin
                        wc <= '0;
                        wr <= wr + 2'd1;
                    end else begin
                        wc <= wc + 2'd1;
                    end
                end
            end
        end
    end

    // ========================================
    // shared 2x2 minor
    // ========================================

    // det2 uses the window itself, det3 the two rows under the pivot row
    // with the pivot column left out
    always_comb begin
        if (is_det3) begin
            row_a = wr + 2'd1;
            col_a = (k == 2'd0) ? wc + 2'd1 : wc;
            col_b = (k == 2'd2) ? wc + 2'd1 : wc + 2'd2;
        end else begin
            row_a = wr;
            col_a = wc;
            col_b = wc + 2'd1;
        end
    end

    assign minor = elem(mat_q, row_a, col_a) * elem(mat_q, row_a + 2'd1, col_b)
                 - elem(mat_q, row_a, col_b) * elem(mat_q, row_a + 2'd1, col_a);

    // ========================================
    // cofactor accumulation
    // ========================================

    // first-row pivot of the current window
    assign term = elem(mat_q, wr, wc + k) * minor;

    // signs go + - + along the first row
    always_comb begin
        case (k)
            2'd0:    acc_next = term;
            2'd1:    acc_next = acc - term;
            default: acc_next = acc + term;
        endcase
    end

    // ========================================
    // job and result registers
    // ========================================

    always_ff @(posedge clk) begin
        if (job_valid) begin
            mat_q  <= job.mat;
            mode_q <= job.mode;
            // det3 leaves the top pad bits untouched, so start from zero
            res    <= '0;
        end else if (busy) begin
            acc <= acc_next;
            if (!is_det3) begin
                res <= {res[OUT_W-DET2_W-1:0], minor};
            end else if (k == 2'd2) begin
                res <= {res[OUT_W-DET3_W-1:0],
                        {(DET3_W - ACC_W){acc_next[ACC_W-1]}}, acc_next};
            end
        end
    end

    // zeros outside the strobe
    assign out_data = out_valid ? res : '0;

endmodule

`default_nettype wire

/* matrix_buffer.sv */
// matrix buffer: shifts sixteen entry beats into a store
// and hands the finished matrix over as one job
`default_nettype none

module matrix_buffer #(
    parameter int RUN_LEN = mdc_pkg::N_ENTRIES
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  beat_valid,
    input  wire mdc_pkg::entry_beat_t  beat,
    output logic                       job_valid,
    output mdc_pkg::job_t              job
);

    mdc_pkg::entry_t [RUN_LEN-1:0] store;
    mdc_pkg::entry_t [RUN_LEN-1:0] store_next;
    mdc_pkg::det_mode_e            mode_q;
    // high between the first and the last beat of a matrix
    logic                          filling;

    // newest entry enters at the top, so the first one ends at index 0
    assign store_next = {beat.entry, store[RUN_LEN-1:1]};

    // ========================================
    // control
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filling   <= 1'b0;
            job_valid <= 1'b0;
        end else begin
            job_valid <= beat_valid && beat.last;
            if (beat_valid) begin
                filling <= !beat.last;
            end
        end
    end

    // ========================================
    // store and job register
    // ========================================

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            store <= store_next;
            // mode rides on the first beat only
            if (!filling) begin
                mode_q <= beat.mode;
            end
            // copy out so the store can refill while the engine works
            if (beat.last) begin
                job.mode <= filling ? mode_q : beat.mode;
                job.mat  <= store_next;
            end
        end
    end

endmodule

`default_nettype wire

/* mdc_input_stage.sv */
// input stage: corrects mode and entry codewords, checks the mode
// and emits one registered entry beat per accepted input cycle
`default_nettype none

module mdc_input_stage #(
    parameter int RUN_LEN = mdc_pkg::N_ENTRIES
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid,
    input  wire logic [8:0]        in_mode,
    input  wire logic [14:0]       in_data,
    output logic                   beat_valid,
    output mdc_pkg::entry_beat_t   beat
);

    localparam int MODE_CODE_W = 9;
    localparam int DATA_CODE_W = 15;
    localparam int CNT_W = $clog2(RUN_LEN);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(RUN_LEN - 1);

    mdc_pkg::mode_t     mode_dec;
    mdc_pkg::entry_t    entry_dec;
    mdc_pkg::det_mode_e run_mode;
    logic [CNT_W-1:0]   cnt;
    logic               run_ok;
    logic               first;
    logic               last_cyc;
    logic               mode_ok;
    logic               accept;

    // ========================================
    // codeword correction
    // ========================================

    hamming_decoder #(
        .payload_t (mdc_pkg::mode_t),
        .CODE_W    (MODE_CODE_W)
    ) u_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    hamming_decoder #(
        .payload_t (mdc_pkg::entry_t),
        .CODE_W    (DATA_CODE_W)
    ) u_entry_dec (
        .code (in_data),
        .data (entry_dec)
    );

    // ========================================
    // run tracking
    // ========================================

    assign first    = (cnt == '0);
    assign last_cyc = (cnt == LAST_IDX);
    assign mode_ok  = (mode_dec == mdc_pkg::MODE_DET2) || (mode_dec == mdc_pkg::MODE_DET3);
    // first cycle decides from the live mode, the rest follow the flag
    assign accept   = first ? mode_ok : run_ok;

    // position inside the run, wraps after the last entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            run_ok <= 1'b0;
        end else if (in_valid) begin
            cnt <= last_cyc ? '0 : cnt + 1'b1;
            if (first) begin
                run_ok <= mode_ok;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= in_valid && accept;
        end
    end

    // payload side, qualified by beat_valid downstream
    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (first) begin
                run_mode <= mdc_pkg::det_mode_e'(mode_dec);
            end
            beat.entry <= entry_dec;
            beat.mode  <= first ? mdc_pkg::det_mode_e'(mode_dec) : run_mode;
            beat.last  <= last_cyc;
        end
    end

endmodule

`default_nettype wire

/* hamming_decoder.sv */
// single-error-correcting hamming decoder
// position 1 is the codeword msb, parity at powers of two
`default_nettype none

module hamming_decoder #(
    parameter type payload_t = logic,
    parameter int CODE_W = 15
) (
    input  wire logic [CODE_W-1:0] code,
    output payload_t               data
);

    localparam int DATA_W = $bits(payload_t);
    // enough bits to name every codeword position
    localparam int SYN_W = $clog2(CODE_W + 1);

    logic [SYN_W-1:0]  syndrome;
    logic [CODE_W-1:0] fixed;
    logic [DATA_W-1:0] bits;

    // syndrome is the xor of the positions of all set bits
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (code[CODE_W-p]) begin
                syndrome = syndrome ^ SYN_W'(p);
            end
        end
    end

    // flip the addressed position, ignore syndromes past the codeword end
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= CODE_W) begin
            fixed[CODE_W-int'(syndrome)] = ~code[CODE_W-int'(syndrome)];
        end
    end

    // gather the non-parity positions, first one lands in the data msb
    always_comb begin
        int k;
        k = DATA_W - 1;
        bits = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                bits[k] = fixed[CODE_W-p];
                k = k - 1;
            end
        end
    end

    assign data = payload_t'(bits);

endmodule

`default_nettype wire

/* mdc_pkg.sv */
// shared widths, mode encoding and packed types
// for the hamming-protected matrix determinant calculator
`default_nettype none

package mdc_pkg;

    // ========================================
    // widths
    // ========================================

    // one corrected matrix entry
    localparam int ENTRY_W = 11;
    // corrected mode payload
    localparam int MODE_W = 5;
    // matrix side and entry count
    localparam int DIM = 4;
    localparam int N_ENTRIES = DIM * DIM;
    // 11x11 product plus one bit for the difference
    localparam int DET2_W = 23;
    // 3x3 result field, sign extended in the output word
    localparam int DET3_W = 51;
    // nine det2 fields or four det3 fields plus three pad bits
    localparam int OUT_W = 207;

    // ========================================
    // scalar types
    // ========================================

    typedef logic signed [ENTRY_W-1:0] entry_t;
    typedef logic [MODE_W-1:0] mode_t;

    // only these two payloads start a run
    typedef enum mode_t {
        MODE_DET2 = 5'b00100,
        MODE_DET3 = 5'b00110
    } det_mode_e;

    // ========================================
    // bundles between the stages
    // ========================================

    // one entry per accepted input cycle
    typedef struct packed {
        entry_t    entry;
        // only meaningful on the first beat of a run
        det_mode_e mode;
        // marks the sixteenth entry
        logic      last;
    } entry_beat_t;

    // row-major, element 0 is row 0 column 0
    typedef entry_t [N_ENTRIES-1:0] matrix_t;

    // complete matrix handed to the engine
    typedef struct packed {
        det_mode_e mode;
        matrix_t   mat;
    } job_t;

    typedef logic [OUT_W-1:0] result_t;

endpackage

`default_nettype wire
